//--- all.f
logic/capture_pkg.sv
logic/apb_map_pkg.sv
logic/sync_flops.sv
logic/async_fifo.sv
logic/sample_packer.sv
logic/apb_fifo_reader.sv
logic/capture_top.sv
dv/capture_checker.sv
dv/capture_tb.sv

//--- dv/capture_checker.sv
module capture_checker #(
    parameter int fifo_addr          = 4,
    parameter int almost_empty_level = 2
) (
    input  logic                            wr_clk,
    input  logic                            wr_rst,
    input  logic                            sample_valid,
    input  logic [capture_pkg::chan_w-1:0]  sample_channel,
    input  logic [capture_pkg::value_w-1:0] sample_value,
    input  logic                            rd_clk,
    input  logic                            rd_rst,
    input  logic                            psel,
    input  logic                            penable,
    input  logic                            pwrite,
    input  logic [apb_map_pkg::paddr_w-1:0] paddr,
    input  logic [apb_map_pkg::pdata_w-1:0] prdata,
    input  logic                            pready,
    input  logic                            pslverr,
    input  logic                            reads_only,
    input  logic                            end_of_test,
    output int                              error_count,
    output logic                            all_accounted,
    output logic                            final_done
);
    timeunit 1ns;
    timeprecision 100ps;

    import capture_pkg::*;
    import apb_map_pkg::*;

    // samples in the order the source sent them
    sample_fields_t     sent_q [$];
    int                 errors = 0;
    int                 sent_total = 0;
    int                 read_samples = 0;
    int                 marker_sum = 0;
    int                 pending_skip = 0;
    int                 prev_sent = 0;
    logic [pdata_w-1:0] prev_status = '0;
    logic               have_prev = 1'b0;
    logic               err_since_status = 1'b0;
    logic               finished = 1'b0;

    assign error_count   = errors;
    assign final_done    = finished;
    assign all_accounted = (sent_total == read_samples + marker_sum);

    task automatic check_equal(input string name, input int expected, input int actual);
        if (expected != actual) begin
            errors++;
            $display("FAILED at %0t ns: %s expected 0x%0h, got 0x%0h",
                     $time, name, expected, actual);
        end
    endtask

    task automatic check_status();
        int cnt;
        int prev_cnt;
        cnt      = int'(prdata[status_count_lsb +: fifo_addr + 1]);
        prev_cnt = int'(prev_status[status_count_lsb +: fifo_addr + 1]);
        check_equal("pslverr", 0, pslverr);
        check_equal("status.empty", cnt == 0, prdata[status_empty_bit]);
        check_equal("status.almost_empty", cnt <= almost_empty_level,
                    prdata[status_almost_empty_bit]);
        // nothing sent yet, so the FIFO must still be empty
        if (sent_total == 0) begin
            check_equal("status.count", 0, cnt);
        end
        if (reads_only && have_prev && sent_total == prev_sent) begin
            if (cnt > prev_cnt) begin
                errors++;
                $display("FAILED at %0t ns: status.count expected at most %0d, got %0d",
                         $time, prev_cnt, cnt);
            end
            if (err_since_status) begin
                check_equal("status word", prev_status, prdata);
            end
        end
        prev_status      = prdata;
        prev_sent        = sent_total;
        have_prev        = reads_only;
        err_since_status = 1'b0;
    endtask

    task automatic check_data();
        fifo_entry_t    e;
        sample_fields_t exp;
        int             skipped;
        if (sent_total == 0) begin
            check_equal("pslverr", 1, pslverr);
        end
        if (pslverr) begin
            check_equal("prdata", 0, prdata);
        end else begin
            e = prdata[entry_w-1:0];
            if (e.marker.kind == kind_marker) begin
                pending_skip += e.marker.drop_count;
                marker_sum   += e.marker.drop_count;
            end else begin
                // samples counted by the markers sit at the head of the queue
                skipped = 0;
                while (skipped < pending_skip && sent_q.size() > 0) begin
                    exp = sent_q.pop_front();
                    skipped++;
                end
                check_equal("samples skipped by markers", pending_skip, skipped);
                pending_skip = 0;
                read_samples++;
                if (sent_q.size() == 0) begin
                    errors++;
                    $display("sample read at %0t ns with no sample left to match", $time);
                end else begin
                    exp = sent_q.pop_front();
                    check_equal("entry.sample.channel", exp.channel, e.sample.channel);
                    check_equal("entry.sample.value", exp.value, e.sample.value);
                end
            end
        end
    endtask

    always @(posedge wr_clk) begin
        sample_fields_t s;
        if (!wr_rst && sample_valid) begin
            s.kind    = kind_sample;
            s.channel = sample_channel;
            s.value   = sample_value;
            sent_q.push_back(s);
            sent_total++;
        end
    end

    always @(posedge rd_clk) begin
        if (end_of_test && !finished) begin
            check_equal("samples sent", sent_total, read_samples + marker_sum);
            check_equal("dropped samples left unread", pending_skip, sent_q.size());
            finished = 1'b1;
        end else if (!rd_rst && psel && penable) begin
            // no wait states, every access phase completes at once
            check_equal("pready", 1, pready);
            if (pwrite || (paddr != reg_status && paddr != reg_data)) begin
                check_equal("pslverr", 1, pslverr);
                err_since_status = 1'b1;
            end else if (paddr == reg_status) begin
                check_status();
            end else begin
                check_data();
            end
        end
    end

endmodule

//--- dv/capture_tb.sv
module capture_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import capture_pkg::*;
    import apb_map_pkg::*;

    localparam int fifo_addr          = 4;
    localparam int almost_empty_level = 2;
    localparam int sync_stages        = 2;
    localparam int poll_limit         = 200;
    // reads column value meaning read until every sample is accounted for
    localparam int drain_all          = -1;
    localparam int rows               = 5;
    // entries left waiting in the FIFO while bus errors are exercised
    localparam int bracket_fill       = 3;

    // stimulus table, one array per column
    int row_cycles  [rows] = '{6, 5, 28, 40, 4};
    int row_channel [rows] = '{1, 5, 3, 6, 2};
    int row_start   [rows] = '{'h100, 'hffd, 'h200, 'h400, 'h050};
    int row_gappy   [rows] = '{1, 1, 0, 0, 1};
    int row_reads   [rows] = '{6, 5, drain_all, drain_all, 4};

    logic               wr_clk = 1'b0;
    logic               rd_clk = 1'b0;
    logic               wr_rst;
    logic               rd_rst;
    logic               sample_valid;
    logic [chan_w-1:0]  sample_channel;
    logic [value_w-1:0] sample_value;
    logic               psel;
    logic               penable;
    logic               pwrite;
    logic [paddr_w-1:0] paddr;
    logic [pdata_w-1:0] prdata;
    logic               pready;
    logic               pslverr;
    logic               reads_only;
    logic               end_of_test;
    logic               all_accounted;
    logic               final_done;
    int                 error_count;
    int                 timeout_count = 0;
    int                 rnd;

    always #15 wr_clk = ~wr_clk;
    always #20 rd_clk = ~rd_clk;

    capture_top #(
        .fifo_addr          (fifo_addr),
        .almost_empty_level (almost_empty_level),
        .sync_stages        (sync_stages)
    ) capture_top_i (
        .wr_clk         (wr_clk),
        .wr_rst         (wr_rst),
        .sample_valid   (sample_valid),
        .sample_channel (sample_channel),
        .sample_value   (sample_value),
        .rd_clk         (rd_clk),
        .rd_rst         (rd_rst),
        .psel           (psel),
        .penable        (penable),
        .pwrite         (pwrite),
        .paddr          (paddr),
        .prdata         (prdata),
        .pready         (pready),
        .pslverr        (pslverr)
    );

    capture_checker #(
        .fifo_addr          (fifo_addr),
        .almost_empty_level (almost_empty_level)
    ) capture_checker_i (
        .wr_clk         (wr_clk),
        .wr_rst         (wr_rst),
        .sample_valid   (sample_valid),
        .sample_channel (sample_channel),
        .sample_value   (sample_value),
        .rd_clk         (rd_clk),
        .rd_rst         (rd_rst),
        .psel           (psel),
        .penable        (penable),
        .pwrite         (pwrite),
        .paddr          (paddr),
        .prdata         (prdata),
        .pready         (pready),
        .pslverr        (pslverr),
        .reads_only     (reads_only),
        .end_of_test    (end_of_test),
        .error_count    (error_count),
        .all_accounted  (all_accounted),
        .final_done     (final_done)
    );

    task automatic report_timeout(input string what);
        timeout_count++;
        $display("timeout at %0t ns: %s", $time, what);
    endtask

    function automatic int status_count(input logic [pdata_w-1:0] word);
        return int'(word[status_count_lsb +: fifo_addr + 1]);
    endfunction

    task automatic drive_samples(input int n, input int channel, input int start,
                                 input int gappy);
        int gap;
        int v;
        @(posedge wr_clk);
        #2;
        for (int i = 0; i < n; i++) begin
            v              = start + i;
            sample_valid   = 1'b1;
            sample_channel = channel[chan_w-1:0];
            sample_value   = v[value_w-1:0];
            @(posedge wr_clk);
            #2;
            if (gappy != 0) begin
                sample_valid = 1'b0;
                gap          = $urandom_range(3, 1);
                repeat (gap) begin
                    @(posedge wr_clk);
                    #2;
                end
            end
        end
        sample_valid = 1'b0;
    endtask

    task automatic apb_access(input logic is_write, input logic [paddr_w-1:0] addr,
                              output logic [pdata_w-1:0] data);
        int waits;
        waits = 0;
        @(posedge rd_clk);
        #2;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = is_write;
        paddr   = addr;
        @(posedge rd_clk);
        #2;
        penable = 1'b1;
        // access phase ends on the edge that sees pready
        do begin
            @(posedge rd_clk);
            waits++;
        end while (!pready && waits < poll_limit);
        if (!pready) begin
            report_timeout("APB access never saw pready");
        end
        data = prdata;
        #2;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic read_entries(input int n);
        logic [pdata_w-1:0] word;
        int                 polls;
        for (int i = 0; i < n; i++) begin
            polls = 0;
            do begin
                apb_access(1'b0, reg_status, word);
                polls++;
            end while (status_count(word) == 0 && polls < poll_limit);
            if (status_count(word) == 0) begin
                report_timeout("FIFO stayed empty while an entry was expected");
            end else begin
                apb_access(1'b0, reg_data, word);
            end
        end
    endtask

    task automatic drain_fifo();
        logic [pdata_w-1:0] word;
        int                 polls;
        polls = 0;
        while (!all_accounted && polls < poll_limit) begin
            apb_access(1'b0, reg_status, word);
            if (status_count(word) != 0) begin
                apb_access(1'b0, reg_data, word);
            end
            polls++;
        end
        if (!all_accounted) begin
            report_timeout("drain ended with samples still unaccounted");
        end
    endtask

    initial begin
        logic [pdata_w-1:0] word;
        int                 waits;
        int                 polls;
        wr_rst         = 1'b1;
        rd_rst         = 1'b1;
        sample_valid   = 1'b0;
        sample_channel = '0;
        sample_value   = '0;
        psel           = 1'b0;
        penable        = 1'b0;
        pwrite         = 1'b0;
        paddr          = '0;
        reads_only     = 1'b0;
        end_of_test    = 1'b0;
        rnd            = $urandom(7);
        fork
            begin
                repeat (3) @(posedge wr_clk);
                #2;
                wr_rst = 1'b0;
            end
            begin
                repeat (3) @(posedge rd_clk);
                #2;
                rd_rst = 1'b0;
            end
        join

        // fresh FIFO, nothing to pop yet
        apb_access(1'b0, reg_status, word);
        apb_access(1'b0, reg_data, word);

        for (int r = 0; r < rows; r++) begin
            drive_samples(row_cycles[r], row_channel[r], row_start[r], row_gappy[r]);
            if (row_reads[r] == drain_all) begin
                reads_only = 1'b1;
                drain_fifo();
                reads_only = 1'b0;
            end else begin
                read_entries(row_reads[r]);
            end
        end

        // writes and unknown offsets bracketed by status reads, with entries waiting
        drive_samples(bracket_fill, 4, 'h300, 0);
        polls = 0;
        do begin
            apb_access(1'b0, reg_status, word);
            polls++;
        end while (status_count(word) != bracket_fill && polls < poll_limit);
        if (status_count(word) != bracket_fill) begin
            report_timeout("queued entries never showed up in the status count");
        end
        reads_only = 1'b1;
        apb_access(1'b0, reg_status, word);
        apb_access(1'b1, reg_data, word);
        apb_access(1'b1, reg_status, word);
        apb_access(1'b0, 4'h8, word);
        apb_access(1'b0, reg_status, word);
        reads_only = 1'b0;
        read_entries(bracket_fill);

        end_of_test = 1'b1;
        waits = 0;
        while (!final_done && waits < poll_limit) begin
            @(posedge rd_clk);
            #2;
            waits++;
        end
        if (!final_done) begin
            report_timeout("checker never ran its final accounting");
        end
        $display("errors: %0d, timeouts: %0d", error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- logic/apb_fifo_reader.sv
module apb_fifo_reader #(
    parameter int fifo_addr = 4
) (
    input  logic                            rd_clk,
    input  logic                            rd_rst,
    input  logic                            psel,
    input  logic                            penable,
    input  logic                            pwrite,
    input  logic [apb_map_pkg::paddr_w-1:0] paddr,
    output logic [apb_map_pkg::pdata_w-1:0] prdata,
    output logic                            pready,
    output logic                            pslverr,
    input  capture_pkg::fifo_entry_t        rd_data_out,
    input  logic                            empty,
    input  logic                            almost_empty,
    input  logic [fifo_addr:0]              count,
    output logic                            pop
);

    import capture_pkg::*;
    import apb_map_pkg::*;

    logic               setup;
    logic               status_rd;
    logic               data_ok;
    logic [pdata_w-1:0] status_word;
    logic [pdata_w-1:0] data_word;
    logic [pdata_w-1:0] rdata_next;
    logic [pdata_w-1:0] rdata_q;
    logic               err_q;
    logic               pop_ok_q;

    always_comb begin
        status_word = '0;
        status_word[status_empty_bit]                 = empty;
        status_word[status_almost_empty_bit]          = almost_empty;
        status_word[status_count_lsb +: fifo_addr + 1] = count;
        data_word = '0;
        data_word[data_entry_lsb +: entry_w]          = rd_data_out;
    end

    assign setup     = psel && !penable;
    assign status_rd = !pwrite && (paddr == reg_status);
    // head cannot change before the access phase, only our own pop moves it
    assign data_ok   = !pwrite && (paddr == reg_data) && !empty;

    always_comb begin
        if (status_rd) begin
            rdata_next = status_word;
        end else if (data_ok) begin
            rdata_next = data_word;
        end else begin
            rdata_next = '0;
        end
    end

    // response is prepared during setup and presented in the access phase
    always_ff @(posedge rd_clk) begin
        if (setup) begin
            rdata_q <= rdata_next;
        end
    end

    always_ff @(posedge rd_clk) begin
        if (rd_rst) begin
            err_q    <= 1'b0;
            pop_ok_q <= 1'b0;
        end else if (setup) begin
            err_q    <= !(status_rd || data_ok);
            pop_ok_q <= data_ok;
        end else if (penable) begin
            pop_ok_q <= 1'b0;
        end
    end

    // no wait states
    assign pready  = 1'b1;
    assign prdata  = rdata_q;
    assign pslverr = psel && penable && err_q;
    assign pop     = psel && penable && pop_ok_q;

    // a pop follows a setup phase and finds data in the FIFO
    assert property (@(posedge rd_clk) disable iff (rd_rst)
        pop |-> psel && penable && !empty && $past(psel && !penable))
        else $error("apb_fifo_reader: pop outside a valid access phase");

endmodule

//--- logic/apb_map_pkg.sv
package apb_map_pkg;

    // bus widths
    localparam int paddr_w = 4;
    localparam int pdata_w = 32;

    // register offsets
    localparam logic [paddr_w-1:0] reg_status = 4'h0;
    localparam logic [paddr_w-1:0] reg_data   = 4'h4;

    // status word layout
    localparam int status_empty_bit        = 0;
    localparam int status_almost_empty_bit = 1;
    localparam int status_count_lsb        = 8;

    // data word carries the entry from bit 0 up
    localparam int data_entry_lsb = 0;

endpackage

//--- logic/async_fifo.sv
module async_fifo #(
    parameter int fifo_addr          = 4,
    parameter int almost_empty_level = 2,
    parameter int sync_stages        = 2
) (
    // write side
    input  logic                   wr_clk,
    input  logic                   wr_rst,
    input  logic                   push,
    input  capture_pkg::fifo_entry_t entry,
    output logic                   full,

    // read side
    input  logic                   rd_clk,
    input  logic                   rd_rst,
    input  logic                   pop,
    output capture_pkg::fifo_entry_t rd_data_out,
    output logic                   empty,
    output logic                   almost_empty,
    output logic [fifo_addr:0]     count
);

    import capture_pkg::*;

    localparam int depth = 2 ** fifo_addr;

    // flips the wrap bit so a full pointer compares equal
    localparam logic [fifo_addr:0] msb = {1'b1, {fifo_addr{1'b0}}};

    function automatic logic [fifo_addr:0] to_gray(input logic [fifo_addr:0] b);
        return b ^ (b >> 1);
    endfunction

    function automatic logic [fifo_addr:0] from_gray(input logic [fifo_addr:0] g);
        logic [fifo_addr:0] b;
        b[fifo_addr] = g[fifo_addr];
        for (int i = fifo_addr - 1; i >= 0; i--) begin
            b[i] = b[i+1] ^ g[i];
        end
        return b;
    endfunction

    fifo_entry_t mem [depth];

    logic [fifo_addr:0] wr_addr;
    logic [fifo_addr:0] wr_addr_next;
    logic [fifo_addr:0] wr_addr_gray;
    logic [fifo_addr:0] wr_rd_addr_gray;
    logic [fifo_addr:0] wr_rd_addr;
    logic [fifo_addr:0] free;
    logic [fifo_addr:0] free_next;

    logic [fifo_addr:0] rd_addr;
    logic [fifo_addr:0] rd_addr_next;
    logic [fifo_addr:0] rd_addr_gray;
    logic [fifo_addr:0] rd_wr_addr_gray;
    logic [fifo_addr:0] rd_wr_addr;
    logic [fifo_addr:0] count_next;

    // storage, no reset
    always_ff @(posedge wr_clk) begin
        if (push) begin
            mem[wr_addr[fifo_addr-1:0]] <= entry;
        end
    end

    // head is read ahead with the next pointer so a pop shows the new head next edge
    always_ff @(posedge rd_clk) begin
        rd_data_out <= mem[rd_addr_next[fifo_addr-1:0]];
    end

    // write domain
    assign wr_rd_addr   = from_gray(wr_rd_addr_gray);
    assign wr_addr_next = push ? wr_addr + 1'b1 : wr_addr;
    assign free_next    = (wr_rd_addr ^ msb) - wr_addr_next;

    always_ff @(posedge wr_clk) begin
        if (wr_rst) begin
            wr_addr      <= '0;
            wr_addr_gray <= '0;
            // held full through reset
            free         <= '0;
            full         <= 1'b1;
        end else begin
            wr_addr      <= wr_addr_next;
            wr_addr_gray <= to_gray(wr_addr_next);
            free         <= free_next;
            full         <= (free_next == '0);
        end
    end

    // read domain
    assign rd_wr_addr   = from_gray(rd_wr_addr_gray);
    assign rd_addr_next = pop ? rd_addr + 1'b1 : rd_addr;
    assign count_next   = rd_wr_addr - rd_addr_next;

    always_ff @(posedge rd_clk) begin
        if (rd_rst) begin
            rd_addr      <= '0;
            rd_addr_gray <= '0;
            count        <= '0;
            empty        <= 1'b1;
            almost_empty <= 1'b1;
        end else begin
            rd_addr      <= rd_addr_next;
            rd_addr_gray <= to_gray(rd_addr_next);
            count        <= count_next;
            empty        <= (rd_wr_addr == rd_addr_next);
            almost_empty <= (count_next <= almost_empty_level);
        end
    end

    // read pointer into write domain
    sync_flops #(
        .width       (fifo_addr + 1),
        .sync_stages (sync_stages)
    ) sync_rd_to_wr (
        .clk (wr_clk),
        .rst (wr_rst),
        .d   (rd_addr_gray),
        .q   (wr_rd_addr_gray)
    );

    // write pointer into read domain
    sync_flops #(
        .width       (fifo_addr + 1),
        .sync_stages (sync_stages)
    ) sync_wr_to_rd (
        .clk (rd_clk),
        .rst (rd_rst),
        .d   (wr_addr_gray),
        .q   (rd_wr_addr_gray)
    );

    // overflow
    assert property (@(posedge wr_clk) disable iff (wr_rst) push |-> !full)
        else $error("async_fifo: push while full");

    // underflow
    assert property (@(posedge rd_clk) disable iff (rd_rst) pop |-> !empty)
        else $error("async_fifo: pop while empty");

    // a stale read pointer may only under-report space, never exceed the depth
    assert property (@(posedge wr_clk) disable iff (wr_rst) free <= depth)
        else $error("async_fifo: free count beyond depth");

endmodule

//--- logic/capture_pkg.sv
package capture_pkg;

    // sample fields
    localparam int chan_w  = 3;
    localparam int value_w = 12;

    // one FIFO word, top bit tells the two formats apart
    localparam int entry_w = 16;

    // saturating count of samples lost while the FIFO was full
    localparam int drop_w   = 12;
    localparam int rsvd_w   = entry_w - 1 - drop_w;
    localparam logic [drop_w-1:0] drop_max = '1;

    localparam logic kind_sample = 1'b0;
    localparam logic kind_marker = 1'b1;

    typedef struct packed {
        logic               kind;
        logic [chan_w-1:0]  channel;
        logic [value_w-1:0] value;
    } sample_fields_t;

    typedef struct packed {
        logic               kind;
        logic [rsvd_w-1:0]  reserved;
        logic [drop_w-1:0]  drop_count;
    } marker_fields_t;

    typedef union packed {
        sample_fields_t sample;
        marker_fields_t marker;
    } fifo_entry_t;

endpackage

//--- logic/capture_top.sv
module capture_top #(
    parameter int fifo_addr          = 4,
    parameter int almost_empty_level = 2,
    parameter int sync_stages        = 2
) (
    // sample source, write domain
    input  logic                            wr_clk,
    input  logic                            wr_rst,
    input  logic                            sample_valid,
    input  logic [capture_pkg::chan_w-1:0]  sample_channel,
    input  logic [capture_pkg::value_w-1:0] sample_value,

    // host APB, read domain
    input  logic                            rd_clk,
    input  logic                            rd_rst,
    input  logic                            psel,
    input  logic                            penable,
    input  logic                            pwrite,
    input  logic [apb_map_pkg::paddr_w-1:0] paddr,
    output logic [apb_map_pkg::pdata_w-1:0] prdata,
    output logic                            pready,
    output logic                            pslverr
);

    import capture_pkg::*;

    logic               push;
    fifo_entry_t        entry;
    logic               full;
    logic               pop;
    fifo_entry_t        rd_data_out;
    logic               empty;
    logic               almost_empty;
    logic [fifo_addr:0] count;

    sample_packer sample_packer_i (
        .wr_clk         (wr_clk),
        .wr_rst         (wr_rst),
        .sample_valid   (sample_valid),
        .sample_channel (sample_channel),
        .sample_value   (sample_value),
        .full           (full),
        .push           (push),
        .entry          (entry)
    );

    async_fifo #(
        .fifo_addr          (fifo_addr),
        .almost_empty_level (almost_empty_level),
        .sync_stages        (sync_stages)
    ) async_fifo_i (
        .wr_clk       (wr_clk),
        .wr_rst       (wr_rst),
        .push         (push),
        .entry        (entry),
        .full         (full),
        .rd_clk       (rd_clk),
        .rd_rst       (rd_rst),
        .pop          (pop),
        .rd_data_out  (rd_data_out),
        .empty        (empty),
        .almost_empty (almost_empty),
        .count        (count)
    );

    apb_fifo_reader #(
        .fifo_addr (fifo_addr)
    ) apb_fifo_reader_i (
        .rd_clk       (rd_clk),
        .rd_rst       (rd_rst),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .paddr        (paddr),
        .prdata       (prdata),
        .pready       (pready),
        .pslverr      (pslverr),
        .rd_data_out  (rd_data_out),
        .empty        (empty),
        .almost_empty (almost_empty),
        .count        (count),
        .pop          (pop)
    );

endmodule

//--- logic/sample_packer.sv
module sample_packer (
    input  logic                          wr_clk,
    input  logic                          wr_rst,
    input  logic                          sample_valid,
    input  logic [capture_pkg::chan_w-1:0]  sample_channel,
    input  logic [capture_pkg::value_w-1:0] sample_value,
    input  logic                          full,
    output logic                          push,
    output capture_pkg::fifo_entry_t      entry
);

    import capture_pkg::*;

    logic [drop_w-1:0] drop_cnt;

    // a pending marker goes out before any new sample
    always_comb begin
        push  = 1'b0;
        entry = '0;
        if (!full) begin
            if (drop_cnt != '0) begin
                push                    = 1'b1;
                entry.marker.kind       = kind_marker;
                entry.marker.reserved   = '0;
                entry.marker.drop_count = drop_cnt;
            end else if (sample_valid) begin
                push                = 1'b1;
                entry.sample.kind    = kind_sample;
                entry.sample.channel = sample_channel;
                entry.sample.value   = sample_value;
            end
        end
    end

    always_ff @(posedge wr_clk) begin
        if (wr_rst) begin
            drop_cnt <= '0;
        end else if (full) begin
            if (sample_valid && drop_cnt != drop_max) begin
                drop_cnt <= drop_cnt + 1'b1;
            end
        end else if (drop_cnt != '0) begin
            // marker cycle, a sample arriving now is lost and starts the next count
            drop_cnt <= sample_valid ? drop_w'(1) : '0;
        end
    end

    // a valid sample that is not pushed must show up in the drop count
    assert property (@(posedge wr_clk) disable iff (wr_rst)
        sample_valid && !push |=> drop_cnt != '0)
        else $error("sample_packer: dropped sample not counted");

endmodule

//--- logic/sync_flops.sv
module sync_flops #(
    parameter int width       = 5,
    parameter int sync_stages = 2
) (
    input  logic             clk,
    input  logic             rst,
    input  logic [width-1:0] d,
    output logic [width-1:0] q
);

    // stage 0 may go metastable, later stages settle it
    logic [width-1:0] stage [sync_stages];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < sync_stages; i++) begin
                stage[i] <= '0;
            end
        end else begin
            stage[0] <= d;
            for (int i = 1; i < sync_stages; i++) begin
                stage[i] <= stage[i-1];
            end
        end
    end

    assign q = stage[sync_stages-1];

endmodule
